// File: disk_dev.f
rtl/disk_pkg.sv
rtl/disk_apb_regs.sv
rtl/sector_buffer.sv
rtl/disk_xfer_engine.sv
rtl/disk_dev.sv
tb/disk_model.sv
tb/disk_dev_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the disk_dev testbench with Verilator, result taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 --top-module disk_dev_tb \
	-f disk_dev.f -o disk_dev_sim &&
	./obj_dir/disk_dev_sim | tee sim.log
grep -qx "Simulation passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: tb/disk_dev_tb.sv
`timescale 1ns/1ns

module disk_dev_tb;
	import disk_pkg::*;

	typedef enum logic [2:0] {
		k_fill,
		k_readback,
		k_cmd,
		k_poll,
		k_illegal
	} step_kind_e;

	// One row of the test table, err is the expected pslverr
	typedef struct packed {
		step_kind_e  kind;
		logic [9:0]  addr;
		logic [31:0] data;
		logic        err;
	} step_t;

	localparam int unsigned rand_seed = 32'h6a5d_8237;
	// 4 sectors x 512 bytes x 8 cycles, plus margin for APB traffic
	localparam int cycle_limit        = 20000;
	localparam int max_waits          = 8;
	localparam int sector_count       = 4;
	localparam logic [31:0] fill_mult = 32'h9e37_79b9;

	logic     clk;
	logic     rst_n;
	apb_req_t apb;
	apb_rsp_t apb_rsp;
	dev_req_t dev_req;
	dev_rsp_t dev_rsp;
	int       device_errors;

	// Reference buffer as words of byte lanes, reference disk as bytes
	logic [3:0][7:0] ref_buf [buf_words];
	logic [7:0]      ref_disk [sector_count][sector_bytes];

	step_t steps [$];
	int    mismatches;
	int    failures;
	int    cycles;

	disk_dev dut (
		.clk     (clk),
		.rst_n   (rst_n),
		.apb     (apb),
		.apb_rsp (apb_rsp),
		.dev_req (dev_req),
		.dev_rsp (dev_rsp)
	);

	disk_model #(.seed(rand_seed)) u_disk (
		.clk       (clk),
		.rst_n     (rst_n),
		.dev_req   (dev_req),
		.dev_rsp   (dev_rsp),
		.err_count (device_errors)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// APB master and checks
	////////////////////////////////////////////////////////////

	// Setup, access until pready, then back to idle
	task automatic apb_access(input logic wr, input logic [9:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic slverr, output int waits);
		logic got;
		got    = 1'b0;
		waits  = 0;
		rdata  = '0;
		slverr = 1'b0;
		@(negedge clk);
		apb.psel    = 1'b1;
		apb.penable = 1'b0;
		apb.pwrite  = wr;
		apb.paddr   = addr;
		apb.pwdata  = wdata;
		@(negedge clk);
		apb.penable = 1'b1;
		while (!got && waits <= max_waits) begin
			@(posedge clk);
			if (apb_rsp.pready) begin
				got    = 1'b1;
				rdata  = apb_rsp.prdata;
				slverr = apb_rsp.pslverr;
			end else begin
				waits++;
			end
		end
		if (!got) begin
			failures++;
			$display("No pready for address 0x%h within %0d cycles", addr, max_waits);
		end
		@(negedge clk);
		apb.psel    = 1'b0;
		apb.penable = 1'b0;
	endtask

	task automatic check_slverr(input logic [9:0] addr, input logic got, input logic exp);
		if (got !== exp) begin
			mismatches++;
			$display("Mismatch pslverr at 0x%h: got 0x%h, expected 0x%h", addr, got, exp);
		end
	endtask

	task automatic check_waits(input logic [9:0] addr, input int got, input int exp);
		if (got != exp) begin
			failures++;
			$display("Access at 0x%h took %0d wait states instead of %0d", addr, got, exp);
		end
	endtask

	// Command effect on the reference, little-endian lanes
	task automatic apply_command(input disk_op_e op, input int s);
		for (int i = 0; i < sector_bytes; i++) begin
			if (op == op_write) begin
				ref_disk[s][i] = ref_buf[i / 4][i % 4];
			end else if (op == op_read) begin
				ref_buf[i / 4][i % 4] = ref_disk[s][i];
			end
		end
	endtask

	task automatic compare_disk();
		for (int s = 0; s < sector_count; s++) begin
			for (int i = 0; i < sector_bytes; i++) begin
				if (u_disk.mem[s][i] !== ref_disk[s][i]) begin
					mismatches++;
					$display("Mismatch disk sector %0d byte 0x%h: got 0x%h, expected 0x%h",
						s, i, u_disk.mem[s][i], ref_disk[s][i]);
				end
			end
		end
	endtask

	////////////////////////////////////////////////////////////
	// Step kinds
	////////////////////////////////////////////////////////////

	// Pattern words from base to the end of the buffer
	task automatic fill_buffer(input logic [9:0] base, input logic [31:0] seed_word);
		logic [31:0] value;
		logic [31:0] rdata;
		logic        slverr;
		int          waits;
		for (int w = int'(base[8:2]); w < buf_words; w++) begin
			value = seed_word ^ (fill_mult * 32'(w));
			apb_access(1'b1, 10'(w * 4), value, rdata, slverr, waits);
			check_slverr(10'(w * 4), slverr, 1'b0);
			check_waits(10'(w * 4), waits, 0);
			ref_buf[w] = value;
		end
	endtask

	// Buffer reads carry exactly one wait state
	task automatic readback_buffer(input logic [9:0] base);
		logic [31:0] rdata;
		logic        slverr;
		int          waits;
		for (int w = int'(base[8:2]); w < buf_words; w++) begin
			apb_access(1'b0, 10'(w * 4), '0, rdata, slverr, waits);
			check_slverr(10'(w * 4), slverr, 1'b0);
			check_waits(10'(w * 4), waits, 1);
			if (rdata !== ref_buf[w]) begin
				mismatches++;
				$display("Mismatch prdata at 0x%h: got 0x%h, expected 0x%h",
					10'(w * 4), rdata, ref_buf[w]);
			end
		end
	endtask

	task automatic send_command(input logic [31:0] word, input logic exp_err);
		logic [31:0] rdata;
		logic        slverr;
		int          waits;
		apb_access(1'b1, reg_cmd_addr, word, rdata, slverr, waits);
		check_slverr(reg_cmd_addr, slverr, exp_err);
		check_waits(reg_cmd_addr, waits, 0);
		if (!exp_err) begin
			apply_command(disk_op_e'(word[1:0]), int'(word[31:16]));
		end
	endtask

	// Done expected means keep polling until it shows, then check the disk
	task automatic poll_status(input logic [31:0] expected);
		logic [31:0] rdata;
		logic        slverr;
		int          waits;
		apb_access(1'b0, reg_status_addr, '0, rdata, slverr, waits);
		while (expected[1] && !rdata[1]) begin
			apb_access(1'b0, reg_status_addr, '0, rdata, slverr, waits);
		end
		check_slverr(reg_status_addr, slverr, 1'b0);
		check_waits(reg_status_addr, waits, 0);
		if (rdata !== expected) begin
			mismatches++;
			$display("Mismatch status: got 0x%h, expected 0x%h", rdata, expected);
		end
		if (expected[1]) begin
			compare_disk();
		end
	endtask

	// Read then write of the same address, both refused
	task automatic illegal_access(input logic [9:0] addr, input logic [31:0] word,
		input logic exp_err);
		logic [31:0] rdata;
		logic        slverr;
		int          waits;
		apb_access(1'b0, addr, '0, rdata, slverr, waits);
		check_slverr(addr, slverr, exp_err);
		check_waits(addr, waits, 0);
		apb_access(1'b1, addr, word, rdata, slverr, waits);
		check_slverr(addr, slverr, exp_err);
		check_waits(addr, waits, 0);
	endtask

	////////////////////////////////////////////////////////////
	// Step table
	////////////////////////////////////////////////////////////

	function automatic logic [31:0] cmd_word(input disk_op_e op, input logic [15:0] s);
		return {s, 14'd0, op};
	endfunction

	function automatic logic [31:0] status_word(input logic [15:0] s, input logic done);
		return {s, 14'd0, done, 1'b0};
	endfunction

	task automatic add_step(input step_kind_e kind, input logic [9:0] addr,
		input logic [31:0] data, input logic err);
		steps.push_back('{kind: kind, addr: addr, data: data, err: err});
	endtask

	task automatic load_steps();
		add_step(k_poll, 10'h204, status_word(16'd0, 1'b0), 1'b0);
		add_step(k_fill, 10'h000, 32'h1357_9bdf, 1'b0);
		add_step(k_readback, 10'h000, '0, 1'b0);
		// Write sector 1, hit the busy rules meanwhile
		add_step(k_cmd, 10'h200, cmd_word(op_write, 16'd1), 1'b0);
		add_step(k_illegal, 10'h010, 32'hdead_beef, 1'b1);
		add_step(k_cmd, 10'h200, cmd_word(op_read, 16'd2), 1'b1);
		add_step(k_illegal, 10'h1fc, 32'h0bad_f00d, 1'b1);
		add_step(k_poll, 10'h204, status_word(16'd1, 1'b1), 1'b0);
		add_step(k_poll, 10'h204, status_word(16'd1, 1'b0), 1'b0);
		add_step(k_readback, 10'h000, '0, 1'b0);
		// Read the preloaded sector 3
		add_step(k_cmd, 10'h200, cmd_word(op_read, 16'd3), 1'b0);
		add_step(k_illegal, 10'h080, 32'h5a5a_5a5a, 1'b1);
		add_step(k_poll, 10'h204, status_word(16'd3, 1'b1), 1'b0);
		add_step(k_poll, 10'h204, status_word(16'd3, 1'b0), 1'b0);
		add_step(k_readback, 10'h000, '0, 1'b0);
		// Bad op and unmapped address while idle
		add_step(k_cmd, 10'h200, cmd_word(op_none, 16'd2), 1'b1);
		add_step(k_illegal, 10'h208, 32'h1234_5678, 1'b1);
		add_step(k_poll, 10'h204, status_word(16'd3, 1'b0), 1'b0);
		// Upper half refill, write sector 2, read sector 1 back
		add_step(k_fill, 10'h100, 32'h2468_ace0, 1'b0);
		add_step(k_cmd, 10'h200, cmd_word(op_write, 16'd2), 1'b0);
		add_step(k_poll, 10'h204, status_word(16'd2, 1'b1), 1'b0);
		add_step(k_poll, 10'h204, status_word(16'd2, 1'b0), 1'b0);
		add_step(k_cmd, 10'h200, cmd_word(op_read, 16'd1), 1'b0);
		add_step(k_poll, 10'h204, status_word(16'd1, 1'b1), 1'b0);
		add_step(k_readback, 10'h000, '0, 1'b0);
	endtask

	task automatic run_step(input step_t st);
		case (st.kind)
			k_fill:     fill_buffer(st.addr, st.data);
			k_readback: readback_buffer(st.addr);
			k_cmd:      send_command(st.data, st.err);
			k_poll:     poll_status(st.data);
			k_illegal:  illegal_access(st.addr, st.data, st.err);
			default: begin
				failures++;
				$display("Unknown step kind in the table");
			end
		endcase
	endtask

	task automatic print_counts();
		$display("Errors: %0d mismatches, %0d other failures, %0d device errors",
			mismatches, failures, device_errors);
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence and timeout
	////////////////////////////////////////////////////////////

	initial begin
		mismatches = 0;
		failures   = 0;
		rst_n      = 1'b0;
		apb        = '0;
		for (int w = 0; w < buf_words; w++) begin
			ref_buf[w] = '0;
		end
		for (int s = 0; s < sector_count; s++) begin
			for (int i = 0; i < sector_bytes; i++) begin
				ref_disk[s][i] = 8'(i + s);
			end
		end
		load_steps();
		repeat (10) @(negedge clk);
		rst_n = 1'b1;
		@(posedge clk);
		if ({dev_req.enable, apb_rsp.pready, apb_rsp.pslverr} !== 3'b000) begin
			mismatches++;
			$display("Mismatch {enable,pready,pslverr} after reset: got 0x%h, expected 0x0",
				{dev_req.enable, apb_rsp.pready, apb_rsp.pslverr});
		end
		foreach (steps[n]) begin
			run_step(steps[n]);
		end
		@(negedge clk);
		print_counts();
		if (mismatches + failures + device_errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	initial begin
		cycles = 0;
		while (cycles < cycle_limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("Run stopped after %0d cycles with test steps still pending", cycles);
		print_counts();
		$display("Simulation failed");
		$finish;
	end

endmodule

// File: tb/disk_model.sv
`timescale 1ns/1ns

module disk_model #(
	parameter int unsigned seed = 0
) (
	input  logic               clk,
	input  logic               rst_n,
	input  disk_pkg::dev_req_t dev_req,
	output disk_pkg::dev_rsp_t dev_rsp,
	output int                 err_count
);
	import disk_pkg::*;

	localparam int sector_count = 4;
	localparam int max_delay    = 5;

	// Sector store, preloaded with index plus sector
	logic [7:0] mem [sector_count][sector_bytes];

	dev_req_t held;
	logic     open;
	int       delay;
	int       s;

	////////////////////////////////////////////////////////////
	// Device side, driven on the falling edge
	////////////////////////////////////////////////////////////

	initial begin
		void'($urandom(seed));
		dev_rsp   = '0;
		err_count = 0;
		open      = 1'b0;
		delay     = 0;
		held      = '0;
		for (int sec = 0; sec < sector_count; sec++) begin
			for (int i = 0; i < sector_bytes; i++) begin
				mem[sec][i] = 8'(i + sec);
			end
		end
		forever begin
			@(negedge clk);
			if (!rst_n) begin
				dev_rsp = '0;
				open    = 1'b0;
			end else if (dev_rsp.read_done || dev_rsp.write_done) begin
				// One-cycle pulse, engine must have dropped the request by now
				dev_rsp.read_done  = 1'b0;
				dev_rsp.write_done = 1'b0;
				if (dev_req.enable) begin
					err_count++;
					$display("Device request still raised in the cycle after its done pulse");
				end
			end else if (dev_req.enable) begin
				if (!open) begin
					// New request, pick its delay
					open  = 1'b1;
					held  = dev_req;
					delay = int'($urandom_range(max_delay, 0));
				end else if (dev_req !== held) begin
					err_count++;
					$display("Mismatch dev_req while waiting: got 0x%h, expected 0x%h",
						dev_req, held);
				end
				if (delay == 0) begin
					open = 1'b0;
					s    = int'(held.sector);
					if (s >= sector_count) begin
						err_count++;
						$display("Device request for sector %0d outside the model", s);
					end else if (held.we) begin
						mem[s][held.index] = held.wdata;
						dev_rsp.write_done = 1'b1;
					end else begin
						dev_rsp.rdata     = mem[s][held.index];
						dev_rsp.read_done = 1'b1;
					end
				end else begin
					delay--;
				end
			end else if (open) begin
				err_count++;
				$display("Device request withdrawn before its done pulse");
				open = 1'b0;
			end
		end
	end

endmodule

// File: rtl/disk_dev.sv
`timescale 1ns/1ns

module disk_dev (
	input  logic               clk,
	input  logic               rst_n,
	input  disk_pkg::apb_req_t apb,
	output disk_pkg::apb_rsp_t apb_rsp,
	output disk_pkg::dev_req_t dev_req,
	input  disk_pkg::dev_rsp_t dev_rsp
);
	import disk_pkg::*;

	// Host word port
	logic                         h_en;
	logic                         h_we;
	logic [$clog2(buf_words)-1:0] h_addr;
	logic [31:0]                  h_wdata;
	logic [31:0]                  h_rdata;

	// Engine byte port
	logic                  e_en;
	logic                  e_we;
	logic [byte_idx_w-1:0] e_idx;
	logic [7:0]            e_wdata;
	logic [7:0]            e_rdata;

	// Command path
	logic      start;
	disk_cmd_t cmd;
	logic      busy;
	logic      finish;

	////////////////////////////////////////////////////////////
	// Blocks
	////////////////////////////////////////////////////////////

	disk_apb_regs u_regs (
		.clk     (clk),
		.rst_n   (rst_n),
		.apb     (apb),
		.apb_rsp (apb_rsp),
		.h_en    (h_en),
		.h_we    (h_we),
		.h_addr  (h_addr),
		.h_wdata (h_wdata),
		.h_rdata (h_rdata),
		.start   (start),
		.cmd     (cmd),
		.busy    (busy),
		.finish  (finish)
	);

	sector_buffer u_buf (
		.clk     (clk),
		.h_en    (h_en),
		.h_we    (h_we),
		.h_addr  (h_addr),
		.h_wdata (h_wdata),
		.h_rdata (h_rdata),
		.e_en    (e_en),
		.e_we    (e_we),
		.e_idx   (e_idx),
		.e_wdata (e_wdata),
		.e_rdata (e_rdata)
	);

	disk_xfer_engine u_engine (
		.clk     (clk),
		.rst_n   (rst_n),
		.start   (start),
		.cmd     (cmd),
		.busy    (busy),
		.finish  (finish),
		.e_en    (e_en),
		.e_we    (e_we),
		.e_idx   (e_idx),
		.e_wdata (e_wdata),
		.e_rdata (e_rdata),
		.dev_req (dev_req),
		.dev_rsp (dev_rsp)
	);

endmodule

// File: rtl/disk_xfer_engine.sv
`timescale 1ns/1ns

module disk_xfer_engine (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            start,
	input  disk_pkg::disk_cmd_t             cmd,
	output logic                            busy,
	output logic                            finish,
	output logic                            e_en,
	output logic                            e_we,
	output logic [disk_pkg::byte_idx_w-1:0] e_idx,
	output logic [7:0]                      e_wdata,
	input  logic [7:0]                      e_rdata,
	output disk_pkg::dev_req_t              dev_req,
	input  disk_pkg::dev_rsp_t              dev_rsp
);
	import disk_pkg::*;

	xfer_state_e           state;
	disk_op_e              op_q;
	logic [sector_w-1:0]   sector_q;
	logic [byte_idx_w-1:0] idx_q;
	logic [7:0]            rdata_q;
	logic                  finish_q;
	logic                  last;
	logic                  waiting;
	logic                  got_done;

	// Last byte of the sector
	assign last = (idx_q == byte_idx_w'(sector_bytes - 1));

	// Request is up in both handshake states
	assign waiting = (state == st_issue) || (state == st_wait);

	// Only the pulse that matches the direction counts
	assign got_done = (op_q == op_write) ? dev_rsp.write_done : dev_rsp.read_done;

	////////////////////////////////////////////////////////////
	// Transfer FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= st_idle;
			op_q     <= op_none;
			idx_q    <= '0;
			finish_q <= 1'b0;
		end else begin
			finish_q <= 1'b0;
			case (state)
				st_idle: begin
					if (start) begin
						op_q  <= cmd.op;
						idx_q <= '0;
						// Write needs the byte from the buffer first
						if (cmd.op == op_write) begin
							state <= st_fetch;
						end else if (cmd.op == op_read) begin
							state <= st_issue;
						end
					end
				end
				// Buffer byte lands on e_rdata next cycle
				st_fetch: begin
					state <= st_issue;
				end
				st_issue, st_wait: begin
					if (got_done) begin
						if (op_q == op_read) begin
							state <= st_store;
						end else if (last) begin
							state    <= st_idle;
							finish_q <= 1'b1;
						end else begin
							idx_q <= idx_q + 1'b1;
							state <= st_fetch;
						end
					end else begin
						state <= st_wait;
					end
				end
				// Device byte written into its lane
				st_store: begin
					if (last) begin
						state    <= st_idle;
						finish_q <= 1'b1;
					end else begin
						idx_q <= idx_q + 1'b1;
						state <= st_issue;
					end
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

	// Sector and captured device byte
	always_ff @(posedge clk) begin
		if (state == st_idle && start) begin
			sector_q <= cmd.sector;
		end
		if (waiting && dev_rsp.read_done) begin
			rdata_q <= dev_rsp.rdata;
		end
	end

	////////////////////////////////////////////////////////////
	// Outputs
	////////////////////////////////////////////////////////////

	// Finish lands in the first idle cycle, together with busy low
	assign busy   = (state != st_idle);
	assign finish = finish_q;

	assign e_en    = (state == st_fetch) || (state == st_store);
	assign e_we    = (state == st_store);
	assign e_idx   = idx_q;
	assign e_wdata = rdata_q;

	// Write data straight from the buffer read register, held until the next fetch
	assign dev_req.enable = waiting;
	assign dev_req.we     = (op_q == op_write);
	assign dev_req.sector = sector_q;
	assign dev_req.index  = idx_q;
	assign dev_req.wdata  = e_rdata;

	// Request frozen until the device answers
	a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
		dev_req.enable && !(dev_rsp.read_done || dev_rsp.write_done)
		|=> $stable(dev_req));

	// Device answers only an open request
	a_done_enabled: assert property (@(posedge clk) disable iff (!rst_n)
		(dev_rsp.read_done || dev_rsp.write_done) |-> dev_req.enable);

endmodule

// File: rtl/sector_buffer.sv
`timescale 1ns/1ns

module sector_buffer (
	input  logic                                  clk,
	input  logic                                  h_en,
	input  logic                                  h_we,
	input  logic [$clog2(disk_pkg::buf_words)-1:0] h_addr,
	input  logic [31:0]                           h_wdata,
	output logic [31:0]                           h_rdata,
	input  logic                                  e_en,
	input  logic                                  e_we,
	input  logic [disk_pkg::byte_idx_w-1:0]       e_idx,
	input  logic [7:0]                            e_wdata,
	output logic [7:0]                            e_rdata
);
	import disk_pkg::*;

	// Word array, lane 0 is the lowest byte address
	logic [3:0][7:0] mem [buf_words];

	logic [3:0]                     wr_be;
	logic [3:0][7:0]                wr_data;
	logic [$clog2(buf_words)-1:0]   wr_addr;

	// Single write port shared by both views
	always_comb begin
		wr_be   = 4'b0000;
		wr_data = h_wdata;
		wr_addr = h_addr;
		if (h_en && h_we) begin
			wr_be = 4'b1111;
		end else if (e_en && e_we) begin
			// Byte replicated, one lane enabled
			wr_be   = 4'b0001 << e_idx[1:0];
			wr_data = {4{e_wdata}};
			wr_addr = e_idx[8:2];
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < 4; i++) begin
			if (wr_be[i]) begin
				mem[wr_addr][i] <= wr_data[i];
			end
		end
		// Registered reads, outputs hold between reads
		if (h_en && !h_we) begin
			h_rdata <= mem[h_addr];
		end
		if (e_en && !e_we) begin
			e_rdata <= mem[e_idx[8:2]][e_idx[1:0]];
		end
	end

	// Register block keeps the host out while the engine owns the buffer
	a_one_port: assert property (@(posedge clk) !(h_en && e_en));

endmodule

// File: rtl/disk_apb_regs.sv
`timescale 1ns/1ns

module disk_apb_regs (
	input  logic                  clk,
	input  logic                  rst_n,
	input  disk_pkg::apb_req_t    apb,
	output disk_pkg::apb_rsp_t    apb_rsp,
	output logic                  h_en,
	output logic                  h_we,
	output logic [6:0]            h_addr,
	output logic [31:0]           h_wdata,
	input  logic [31:0]           h_rdata,
	output logic                  start,
	output disk_pkg::disk_cmd_t   cmd,
	input  logic                  busy,
	input  logic                  finish
);
	import disk_pkg::*;

	logic      access;
	logic      sel_buf;
	logic      sel_cmd;
	logic      sel_status;
	logic      sel_none;
	logic      buf_rd;
	logic      buf_err;
	logic      cmd_err;
	logic      err;
	logic      ready;
	logic      rd_wait;
	logic      done_q;
	disk_op_e  wr_op;
	logic      op_ok;
	disk_cmd_t cmd_q;

	////////////////////////////////////////////////////////////
	// Address decode and error rules
	////////////////////////////////////////////////////////////

	assign access     = apb.psel && apb.penable;
	assign sel_buf    = (apb.paddr < reg_cmd_addr);
	assign sel_cmd    = (apb.paddr == reg_cmd_addr);
	assign sel_status = (apb.paddr == reg_status_addr);
	assign sel_none   = !(sel_buf || sel_cmd || sel_status);

	// Op field of a command write
	assign wr_op = disk_op_e'(apb.pwdata[1:0]);
	assign op_ok = (wr_op == op_read) || (wr_op == op_write);

	// Buffer belongs to the engine while busy
	assign buf_err = sel_buf && busy;
	assign cmd_err = sel_cmd && apb.pwrite && (busy || !op_ok);
	assign err     = buf_err || cmd_err || sel_none;

	// Only a good buffer read gets the wait state
	assign buf_rd = sel_buf && !apb.pwrite && !busy;

	// High in the second access cycle of a buffer read
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_wait <= 1'b0;
		end else begin
			rd_wait <= access && buf_rd && !rd_wait;
		end
	end

	assign ready = access && !(buf_rd && !rd_wait);

	////////////////////////////////////////////////////////////
	// Host word port
	////////////////////////////////////////////////////////////

	// Read issued in the first access cycle and data back in the second
	assign h_en    = access && sel_buf && !busy && (apb.pwrite || !rd_wait);
	assign h_we    = apb.pwrite;
	assign h_addr  = apb.paddr[8:2];
	assign h_wdata = apb.pwdata;

	////////////////////////////////////////////////////////////
	// Command and status
	////////////////////////////////////////////////////////////

	// Sector in bits 31:16 and op in bits 1:0
	assign cmd.op     = wr_op;
	assign cmd.sector = apb.pwdata[31:16];
	assign start      = access && sel_cmd && apb.pwrite && !cmd_err;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cmd_q  <= '{op: op_none, sector: '0};
			done_q <= 1'b0;
		end else begin
			if (start) begin
				cmd_q <= cmd;
			end
			// Finish wins over a clearing status read
			if (finish) begin
				done_q <= 1'b1;
			end else if (access && sel_status && !apb.pwrite) begin
				done_q <= 1'b0;
			end
		end
	end

	// Read data mux
	always_comb begin
		apb_rsp.prdata = '0;
		if (!err) begin
			if (sel_buf) begin
				apb_rsp.prdata = h_rdata;
			end else if (sel_status) begin
				apb_rsp.prdata = {cmd_q.sector, 14'd0, done_q, busy};
			end else if (sel_cmd) begin
				apb_rsp.prdata = {cmd_q.sector, 14'd0, cmd_q.op};
			end
		end
	end

	assign apb_rsp.pready  = ready;
	assign apb_rsp.pslverr = ready && err;

	// Engine answers an accepted command with busy on the next cycle
	a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
		start |-> !busy ##1 busy);

	// Buffer read completes in its second access cycle and anything else in its first
	a_ready_access: assert property (@(posedge clk) disable iff (!rst_n)
		apb_rsp.pready |-> access && (buf_rd == $past(access && !apb_rsp.pready)));

endmodule

// File: rtl/disk_pkg.sv
package disk_pkg;

	////////////////////////////////////////////////////////////
	// Sizes and address map
	////////////////////////////////////////////////////////////

	// One sector per command
	localparam int sector_bytes = 512;
	localparam int byte_idx_w   = 9;
	localparam int sector_w     = 16;
	localparam int apb_addr_w   = 10;
	// Four bytes per buffer word
	localparam int buf_words    = 128;

	// Everything below the command register is the buffer window
	localparam logic [apb_addr_w-1:0] reg_cmd_addr    = 10'h200;
	localparam logic [apb_addr_w-1:0] reg_status_addr = 10'h204;

	////////////////////////////////////////////////////////////
	// Encodings
	////////////////////////////////////////////////////////////

	// Command register bits 1:0
	typedef enum logic [1:0] {
		op_none,
		op_read,
		op_write
	} disk_op_e;

	typedef enum logic [2:0] {
		st_idle,
		st_fetch,
		st_issue,
		st_wait,
		st_store
	} xfer_state_e;

	////////////////////////////////////////////////////////////
	// Bundles
	////////////////////////////////////////////////////////////

	// Register block to engine
	typedef struct packed {
		disk_op_e            op;
		logic [sector_w-1:0] sector;
	} disk_cmd_t;

	typedef struct packed {
		logic                  psel;
		logic                  penable;
		logic                  pwrite;
		logic [apb_addr_w-1:0] paddr;
		logic [31:0]           pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [31:0] prdata;
		logic        pready;
		logic        pslverr;
	} apb_rsp_t;

	// Byte request towards the disk device
	typedef struct packed {
		logic                  enable;
		logic                  we;
		logic [sector_w-1:0]   sector;
		logic [byte_idx_w-1:0] index;
		logic [7:0]            wdata;
	} dev_req_t;

	typedef struct packed {
		logic       read_done;
		logic       write_done;
		logic [7:0] rdata;
	} dev_rsp_t;

endpackage
